// File: decode.f
+incdir+common
common/isa_pkg.sv
common/control_pkg.sv
fetch/instr_fetch.sv
control/alu_control.sv
control/control.sv
verilog/id_ex_stage.sv
verilog/decode_top.sv
tests/decode_properties.sv
tests/tb_decode_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_decode_top
FILELIST = decode.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q ">>> FAIL" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_decode_top.sv
`timescale 1ns/100ps
`include "decode_settings.svh"

module tb_decode_top;
	import isa_pkg::*;
	import control_pkg::*;

	typedef struct packed {
		logic [8:0]  ex_bus;
		logic [8:0]  mem_bus;
		logic [1:0]  wb_bus;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] jump_target;
		logic [4:0]  dest;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  shamt;
	} expected_t;

	logic                          clk;
	logic                          reset;
	logic                          wb_cyc;
	logic                          wb_stb;
	logic [`DECODE_ADDR_WIDTH-1:0] wb_adr;
	logic                          wb_ack;
	logic [31:0]                   wb_rdata;
	logic                          ex_valid;
	logic                          ex_ready;
	logic [8:0]                    execute_bus;
	logic [8:0]                    memory_bus;
	logic [1:0]                    writeback_bus;
	logic [31:0]                   ex_pc;
	logic [31:0]                   ex_imm;
	logic [31:0]                   ex_jump_target;
	logic [4:0]                    ex_dest;
	logic [4:0]                    ex_rs;
	logic [4:0]                    ex_rt;
	logic [4:0]                    ex_shamt;

	logic [31:0] mem [0:255];
	logic [31:0] rng_state;
	int          ready_mode;   // 0 random, 1 held low, 2 held high
	logic        zero_waits;
	int          checked;
	int          value_errors;
	int          other_errors;

	decode_top i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus generation

	function automatic logic [5:0] pick_opcode(input int idx);
		case (idx)
			0:  return OP_J;
			1:  return OP_JAL;
			2:  return OP_BEQ;
			3:  return OP_BNE;
			4:  return OP_ADDI;
			5:  return OP_SLTI;
			6:  return OP_ANDI;
			7:  return OP_ORI;
			8:  return OP_XORI;
			9:  return OP_LUI;
			10: return OP_LB;
			11: return OP_LH;
			12: return OP_LW;
			13: return OP_LBU;
			14: return OP_LHU;
			15: return OP_LWU;
			16: return OP_SB;
			17: return OP_SH;
			18: return OP_SW;
			19: return 6'h01;  // Undefined ones from here
			20: return 6'h10;
			21: return 6'h1c;
			22: return 6'h30;
			default: return 6'h3f;
		endcase
	endfunction

	function automatic logic [5:0] pick_funct(input int idx, input logic [5:0] other);
		case (idx)
			0:  return FUNCT_SLL;
			1:  return FUNCT_SRL;
			2:  return FUNCT_SRA;
			3:  return FUNCT_SLLV;
			4:  return FUNCT_SRLV;
			5:  return FUNCT_SRAV;
			6:  return FUNCT_JR;
			7:  return FUNCT_JALR;
			8:  return FUNCT_ADD;
			9:  return FUNCT_ADDU;
			10: return FUNCT_SUB;
			11: return FUNCT_SUBU;
			12: return FUNCT_AND;
			13: return FUNCT_OR;
			14: return FUNCT_XOR;
			15: return FUNCT_NOR;
			16: return FUNCT_SLT;
			17: return FUNCT_SLTU;
			default: return other;  // Anything else
		endcase
	endfunction

	function automatic logic [31:0] make_instr();
		instr_word_t w;
		logic [31:0] sel;
		int          kind;
		w    = next_rand();
		sel  = next_rand();
		kind = int'(sel[31:27]);
		if (kind < 8)
		begin
			w.r_form.opcode = OP_RTYPE;
			w.r_form.funct  = pick_funct(int'(sel[20:16]) % 20, sel[5:0]);
		end
		else
			w.r_form.opcode = pick_opcode(kind - 8);  // 8 to 31 give 24 choices
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference decoder

	function automatic logic [3:0] funct_alu_code(input logic [5:0] fn);
		case (fn)
			FUNCT_SLL:  return SLL;
			FUNCT_SRL:  return SRL;
			FUNCT_SRA:  return SRA;
			FUNCT_SLLV: return SLLV;
			FUNCT_SRLV: return SRLV;
			FUNCT_SRAV: return SRAV;
			FUNCT_ADD:  return ADD;
			FUNCT_ADDU: return ADD;
			FUNCT_SUB:  return SUB;
			FUNCT_SUBU: return SUB;
			FUNCT_AND:  return AND;
			FUNCT_OR:   return OR;
			FUNCT_XOR:  return XOR;
			FUNCT_NOR:  return NOR;
			FUNCT_SLT:  return SLT;
			FUNCT_SLTU: return SLTU;
			default:    return SLL;
		endcase
	endfunction

	function automatic expected_t decode_ref(input instr_word_t w, input logic [31:0] pc);
		expected_t   e;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic        reg_dst;
		logic        shamt_src;
		logic        imm_src;
		logic        jump;
		logic        jump_reg;
		logic        reg_write;
		logic        mem_to_reg;
		logic [3:0]  code;
		logic [8:0]  mb;
		logic [31:0] pc4;
		op         = w.r_form.opcode;
		fn         = w.r_form.funct;
		reg_dst    = 1'b0;
		shamt_src  = 1'b0;
		imm_src    = 1'b0;
		jump       = 1'b0;
		jump_reg   = 1'b0;
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		code       = SLL;
		mb         = '0;
		if (op == OP_RTYPE)
		begin
			jump_reg  = (fn == FUNCT_JR) || (fn == FUNCT_JALR);
			reg_dst   = !jump_reg;
			reg_write = (fn != FUNCT_JR);
			shamt_src = (fn == FUNCT_SLL) || (fn == FUNCT_SRL) || (fn == FUNCT_SRA);
			code      = funct_alu_code(fn);
		end
		else if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU})
		begin
			imm_src             = 1'b1;
			reg_write           = 1'b1;
			mem_to_reg          = 1'b1;
			code                = ADD;
			mb[MEM_READ]        = 1'b1;
			mb[MEM_LOAD_BYTE]   = (op == OP_LB) || (op == OP_LBU);
			mb[MEM_LOAD_HALF]   = (op == OP_LH) || (op == OP_LHU);
			mb[MEM_UNSIGNED]    = (op == OP_LBU) || (op == OP_LHU);
		end
		else if (op inside {OP_SB, OP_SH, OP_SW})
		begin
			imm_src            = 1'b1;
			code               = ADD;
			mb[MEM_WRITE]      = 1'b1;
			mb[MEM_STORE_BYTE] = (op == OP_SB);
			mb[MEM_STORE_HALF] = (op == OP_SH);
		end
		else if (op inside {OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
		begin
			imm_src   = 1'b1;
			reg_write = 1'b1;
			case (op)
				OP_ADDI: code = ADD;
				OP_SLTI: code = SUB;
				OP_ANDI: code = AND;
				OP_ORI:  code = OR;
				OP_XORI: code = XOR;
				default: code = LUI;
			endcase
		end
		else if (op == OP_BEQ || op == OP_BNE)
		begin
			code           = SUB;
			mb[MEM_BRANCH] = 1'b1;
			mb[MEM_BRANCH_NE] = (op == OP_BNE);
		end
		else if (op == OP_J || op == OP_JAL)
		begin
			jump      = 1'b1;
			reg_write = (op == OP_JAL);
		end

		e.ex_bus  = {reg_dst, shamt_src, imm_src, jump, jump_reg, code};
		e.mem_bus = mb;
		e.wb_bus  = {reg_write, mem_to_reg};
		e.pc      = pc;
		if (op inside {OP_ANDI, OP_ORI, OP_XORI})
			e.imm = {16'h0000, w.i_form.imm16};
		else
			e.imm = {{16{w.i_form.imm16[15]}}, w.i_form.imm16};
		pc4           = pc + 32'd4;
		e.jump_target = {pc4[31:28], w.j_form.target26, 2'b00};
		if (op == OP_JAL || (op == OP_RTYPE && fn == FUNCT_JALR))
			e.dest = 5'd31;
		else if (reg_dst)
			e.dest = w.r_form.rd;
		else
			e.dest = w.r_form.rt;
		e.rs    = w.r_form.rs;
		e.rt    = w.r_form.rt;
		e.shamt = w.r_form.shamt;
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and reporting

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
		begin
			value_errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic fail_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	function automatic logic [135:0] ex_snapshot();
		return {execute_bus, memory_bus, writeback_bus, ex_pc, ex_imm, ex_jump_target,
			ex_dest, ex_rs, ex_rt, ex_shamt};
	endfunction

	// Compare process, one expected instruction per transfer
	always @(posedge clk)
	begin
		expected_t   e;
		logic [31:0] pc;
		if (!reset && ex_valid && ex_ready)
		begin
			pc = `DECODE_RESET_PC + 32'(checked) * 32'd4;
			e  = decode_ref(mem[pc[9:2]], pc);
			check_value("ex_pc", e.pc, ex_pc);
			check_value("execute_bus", 32'(e.ex_bus), 32'(execute_bus));
			check_value("memory_bus", 32'(e.mem_bus), 32'(memory_bus));
			check_value("writeback_bus", 32'(e.wb_bus), 32'(writeback_bus));
			check_value("ex_imm", e.imm, ex_imm);
			check_value("ex_jump_target", e.jump_target, ex_jump_target);
			check_value("ex_dest", 32'(e.dest), 32'(ex_dest));
			check_value("ex_rs", 32'(e.rs), 32'(ex_rs));
			check_value("ex_rt", 32'(e.rt), 32'(ex_rt));
			check_value("ex_shamt", 32'(e.shamt), 32'(ex_shamt));
			checked++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wishbone memory model and ex_ready driver

	initial
	begin
		int  waits;
		logic [31:0] r;
		logic busy;
		busy = 1'b0;
		waits = 0;
		forever
		begin
			@(posedge clk);
			#0.5;
			if (reset)
				busy = 1'b0;
			else if (wb_ack)
			begin
				wb_ack = 1'b0;
				busy   = 1'b0;
			end
			else if (wb_cyc)
			begin
				if (!busy)
				begin
					r     = next_rand();
					waits = zero_waits ? 0 : int'(r[31:30]);  // 0 to 3 wait states
					busy  = 1'b1;
				end
				if (waits == 0)
				begin
					wb_ack   = 1'b1;
					wb_rdata = mem[wb_adr[7:0]];
				end
				else
					waits--;
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		forever
		begin
			@(posedge clk);
			#0.5;
			r = next_rand();
			if (ready_mode == 1)
				ex_ready = 1'b0;
			else if (ready_mode == 2)
				ex_ready = 1'b1;
			else
				ex_ready = (r[31:30] != 2'b00);  // Low about a quarter of the time
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		int           n;
		logic [135:0] snap;
		logic [31:0]  acked_pc;
		rng_state    = 32'h86e22a15;
		reset        = 1'b1;
		wb_ack       = 1'b0;
		wb_rdata     = '0;
		ex_ready     = 1'b0;
		ready_mode   = 0;
		zero_waits   = 1'b0;
		checked      = 0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = make_instr();

		repeat (10) @(posedge clk);
		#0.5 reset = 1'b0;

		// Random wait states and stalls
		n = 0;
		while (checked < 300)
		begin
			if (n == 20000)
				fail_on_timeout("fewer than 300 transfers under random stalls");
			n++;
			@(posedge clk);
		end

		// Long stall with a full pipeline, ex_ready low before the snapshot
		ready_mode = 1;
		@(posedge clk);
		n = 0;
		while (!ex_valid)
		begin
			if (n == 200)
				fail_on_timeout("ex_valid never rose in the stall test");
			n++;
			@(posedge clk);
		end
		snap = ex_snapshot();
		for (int c = 0; c < 20; c++)
		begin
			@(posedge clk);
			if (!ex_valid || ex_snapshot() != snap)
			begin
				other_errors++;
				$display("ex outputs changed during the stall at %0t", $time);
			end
			if (c >= 10 && wb_cyc)
			begin
				other_errors++;
				$display("Bus cycle started with a full buffer at %0t", $time);
			end
		end
		ready_mode = 0;

		// Latency with no wait states and no stalls
		zero_waits = 1'b1;
		ready_mode = 2;
		repeat (8) @(posedge clk);
		for (int k = 0; k < 3; k++)
		begin
			n = 0;
			@(posedge clk);
			while (!(wb_cyc && wb_ack))
			begin
				if (n == 100)
					fail_on_timeout("no ack seen in the latency test");
				n++;
				@(posedge clk);
			end
			acked_pc = 32'({wb_adr, 2'b00});
			@(posedge clk);
			if (ex_valid && ex_pc == acked_pc)
			begin
				other_errors++;
				$display("ex_valid rose too early after the ack at %0t", $time);
			end
			@(posedge clk);
			if (!(ex_valid && ex_pc == acked_pc))
			begin
				other_errors++;
				$display("ex_valid did not rise 2 cycles after the ack at %0t", $time);
			end
		end
		repeat (10) @(posedge clk);

		$display("Checked %0d transfers, %0d value errors, %0d other errors",
			checked, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tests/decode_properties.sv
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_properties (
	input logic                                        clk,
	input logic                                        reset,
	input logic                                        wb_cyc,
	input logic                                        wb_stb,
	input logic [`DECODE_ADDR_WIDTH-1:0]               wb_adr,
	input logic                                        wb_ack,
	input logic                                        ex_valid,
	input logic                                        ex_ready,
	input logic [control_pkg::EXECUTE_BUS_W-1:0]   execute_bus,
	input logic [control_pkg::MEMORY_BUS_W-1:0]    memory_bus,
	input logic [control_pkg::WRITEBACK_BUS_W-1:0] writeback_bus,
	input logic [31:0]                                 ex_pc,
	input logic [31:0]                                 ex_imm,
	input logic [31:0]                                 ex_jump_target,
	input logic [4:0]                                  ex_dest,
	input logic [4:0]                                  ex_rs,
	input logic [4:0]                                  ex_rt,
	input logic [4:0]                                  ex_shamt
);

	////////////////////////////////////////////////////////////////////////////
	// Wishbone side

	a_cyc_stb: assert property (@(posedge clk) disable iff (reset) wb_cyc == wb_stb)
		else $error("wb_stb differs from wb_cyc");

	a_adr_hold: assert property (@(posedge clk) disable iff (reset)
			wb_cyc && !wb_ack |=> $stable(wb_adr))
		else $error("wb_adr moved while waiting for ack");

	a_idle_after_ack: assert property (@(posedge clk) disable iff (reset)
			wb_cyc && wb_ack |=> !wb_cyc)
		else $error("new cycle right after an ack");

	////////////////////////////////////////////////////////////////////////////
	// Execute side

	a_ex_hold: assert property (@(posedge clk) disable iff (reset)
			ex_valid && !ex_ready |=> ex_valid
			&& $stable({execute_bus, memory_bus, writeback_bus, ex_pc, ex_imm})
			&& $stable({ex_jump_target, ex_dest, ex_rs, ex_rt, ex_shamt}))
		else $error("ex outputs changed under back-pressure");

	a_reset_clears: assert property (@(posedge clk) reset |=> !ex_valid)
		else $error("ex_valid high after reset");

endmodule

bind decode_top decode_properties i_decode_properties (.*);

// File: verilog/decode_top.sv
`timescale 1ns/100ps
`include "decode_settings.svh"

module decode_top (
	input  logic                                        clk,
	input  logic                                        reset,

	output logic                                        wb_cyc,
	output logic                                        wb_stb,
	output logic [`DECODE_ADDR_WIDTH-1:0]               wb_adr,
	input  logic                                        wb_ack,
	input  logic [31:0]                                 wb_rdata,

	output logic                                        ex_valid,
	input  logic                                        ex_ready,
	output logic [control_pkg::EXECUTE_BUS_W-1:0]   execute_bus,
	output logic [control_pkg::MEMORY_BUS_W-1:0]    memory_bus,
	output logic [control_pkg::WRITEBACK_BUS_W-1:0] writeback_bus,
	output logic [31:0]                                 ex_pc,
	output logic [31:0]                                 ex_imm,
	output logic [31:0]                                 ex_jump_target,
	output logic [4:0]                                  ex_dest,
	output logic [4:0]                                  ex_rs,
	output logic [4:0]                                  ex_rt,
	output logic [4:0]                                  ex_shamt
);
	import isa_pkg::*;
	import control_pkg::*;

	instr_word_t                instr;
	logic [31:0]                instr_pc;
	logic                       instr_valid;
	logic                       instr_ready;
	logic [EXECUTE_BUS_W-1:0]   dec_execute_bus;    // Decoder outputs, same cycle
	logic [MEMORY_BUS_W-1:0]    dec_memory_bus;
	logic [WRITEBACK_BUS_W-1:0] dec_writeback_bus;

	instr_fetch u_instr_fetch (
		.clk         (clk),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_adr      (wb_adr),
		.wb_ack      (wb_ack),
		.wb_rdata    (wb_rdata),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready)
	);

	control u_control (
		.instr         (instr),
		.execute_bus   (dec_execute_bus),
		.memory_bus    (dec_memory_bus),
		.writeback_bus (dec_writeback_bus)
	);

	id_ex_stage u_id_ex_stage (
		.clk              (clk),
		.reset            (reset),
		.instr            (instr),
		.instr_pc         (instr_pc),
		.instr_valid      (instr_valid),
		.instr_ready      (instr_ready),
		.execute_bus_in   (dec_execute_bus),
		.memory_bus_in    (dec_memory_bus),
		.writeback_bus_in (dec_writeback_bus),
		.ex_valid         (ex_valid),
		.ex_ready         (ex_ready),
		.execute_bus      (execute_bus),
		.memory_bus       (memory_bus),
		.writeback_bus    (writeback_bus),
		.ex_pc            (ex_pc),
		.ex_imm           (ex_imm),
		.ex_jump_target   (ex_jump_target),
		.ex_dest          (ex_dest),
		.ex_rs            (ex_rs),
		.ex_rt            (ex_rt),
		.ex_shamt         (ex_shamt)
	);

endmodule

// File: verilog/id_ex_stage.sv
`timescale 1ns/100ps
`include "decode_settings.svh"

module id_ex_stage (
	input  logic                                        clk,
	input  logic                                        reset,
	input  isa_pkg::instr_word_t                        instr,
	input  logic [31:0]                                 instr_pc,
	input  logic                                        instr_valid,
	output logic                                        instr_ready,
	input  logic [control_pkg::EXECUTE_BUS_W-1:0]   execute_bus_in,
	input  logic [control_pkg::MEMORY_BUS_W-1:0]    memory_bus_in,
	input  logic [control_pkg::WRITEBACK_BUS_W-1:0] writeback_bus_in,

	// Execute side
	output logic                                        ex_valid,
	input  logic                                        ex_ready,
	output logic [control_pkg::EXECUTE_BUS_W-1:0]   execute_bus,
	output logic [control_pkg::MEMORY_BUS_W-1:0]    memory_bus,
	output logic [control_pkg::WRITEBACK_BUS_W-1:0] writeback_bus,
	output logic [31:0]                                 ex_pc,
	output logic [31:0]                                 ex_imm,
	output logic [31:0]                                 ex_jump_target,
	output logic [4:0]                                  ex_dest,
	output logic [4:0]                                  ex_rs,
	output logic [4:0]                                  ex_rt,
	output logic [4:0]                                  ex_shamt
);
	import control_pkg::*;

	alu_code_t   alu_code_in;
	logic        zero_extend;  // Logic immediates
	logic        load;
	logic [31:0] imm_ext;
	logic [31:0] pc_plus4;
	logic [4:0]  dest;

	assign instr_ready = !ex_valid || ex_ready;
	assign load        = instr_valid && instr_ready;

	assign alu_code_in = alu_code_t'(execute_bus_in[EX_ALU_CODE_MSB:EX_ALU_CODE_LSB]);
	assign zero_extend = execute_bus_in[EX_ALU_SRC_IMM] && (alu_code_in inside {AND, OR, XOR});
	assign imm_ext     = zero_extend ? {16'h0000, instr.i_form.imm16}
	                                 : {{16{instr.i_form.imm16[15]}}, instr.i_form.imm16};
	assign pc_plus4    = instr_pc + `DECODE_PC_STEP;

	always_comb
	begin
		if (writeback_bus_in[WB_REG_WRITE]
				&& (execute_bus_in[EX_JUMP] || execute_bus_in[EX_JUMP_REG]))
			dest = `DECODE_LINK_REG;  // JAL, JALR
		else if (execute_bus_in[EX_REG_DST])
			dest = instr.r_form.rd;
		else
			dest = instr.r_form.rt;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else if (instr_ready)
			ex_valid <= instr_valid;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			execute_bus    <= execute_bus_in;
			memory_bus     <= memory_bus_in;
			writeback_bus  <= writeback_bus_in;
			ex_pc          <= instr_pc;
			ex_imm         <= imm_ext;
			ex_jump_target <= {pc_plus4[31:28], instr.j_form.target26, 2'b00};
			ex_dest        <= dest;
			ex_rs          <= instr.r_form.rs;
			ex_rt          <= instr.r_form.rt;
			ex_shamt       <= instr.r_form.shamt;
		end
	end

endmodule

// File: control/control.sv
`timescale 1ns/100ps

module control (
	input  isa_pkg::instr_word_t                        instr,
	output logic [control_pkg::EXECUTE_BUS_W-1:0]   execute_bus,
	output logic [control_pkg::MEMORY_BUS_W-1:0]    memory_bus,
	output logic [control_pkg::WRITEBACK_BUS_W-1:0] writeback_bus
);
	import isa_pkg::*;
	import control_pkg::*;

	logic [5:0]                     opcode;
	logic [EX_REG_DST:EX_JUMP_REG]  ex_flags;      // Execute bus without ALU code
	logic                           alu_used;
	aluop_t                         aluop;
	alu_code_t                      alu_code;

	assign opcode = instr.i_form.opcode;

	alu_control u_alu_control (
		.funct    (instr.r_form.funct),
		.aluop    (aluop),
		.alu_code (alu_code)
	);

	// Jumps and undefined opcodes leave the ALU code field at zero
	assign execute_bus = {ex_flags, alu_used ? alu_code : SLL};

	////////////////////////////////////////////////////////////////////////////
	// Main decoder

	always_comb
	begin
		ex_flags      = '0;
		memory_bus    = '0;
		writeback_bus = '0;
		aluop         = ALUOP_RTYPE;
		alu_used      = 1'b1;

		case (opcode)
			OP_RTYPE:
			begin
				writeback_bus[WB_REG_WRITE] = 1'b1;
				case (instr.r_form.funct)
					FUNCT_SLL, FUNCT_SRL, FUNCT_SRA:
					begin
						ex_flags[EX_REG_DST]       = 1'b1;
						ex_flags[EX_ALU_SRC_SHAMT] = 1'b1;  // Shift by shamt
					end
					FUNCT_JR:
					begin
						ex_flags[EX_JUMP_REG]       = 1'b1;
						writeback_bus[WB_REG_WRITE] = 1'b0;
					end
					FUNCT_JALR:
						ex_flags[EX_JUMP_REG] = 1'b1;  // Links to r31
					default:
						ex_flags[EX_REG_DST] = 1'b1;
				endcase
			end

			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
			begin
				ex_flags[EX_ALU_SRC_IMM]     = 1'b1;
				aluop                        = ALUOP_ADD;
				memory_bus[MEM_READ]         = 1'b1;
				memory_bus[MEM_LOAD_BYTE]    = opcode inside {OP_LB, OP_LBU};
				memory_bus[MEM_LOAD_HALF]    = opcode inside {OP_LH, OP_LHU};
				memory_bus[MEM_UNSIGNED]     = opcode inside {OP_LBU, OP_LHU};
				writeback_bus[WB_REG_WRITE]  = 1'b1;
				writeback_bus[WB_MEM_TO_REG] = 1'b1;
			end

			OP_SB, OP_SH, OP_SW:
			begin
				ex_flags[EX_ALU_SRC_IMM]   = 1'b1;
				aluop                      = ALUOP_ADD;
				memory_bus[MEM_WRITE]      = 1'b1;
				memory_bus[MEM_STORE_BYTE] = (opcode == OP_SB);
				memory_bus[MEM_STORE_HALF] = (opcode == OP_SH);
			end

			// Immediate arithmetic and logic
			OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				ex_flags[EX_ALU_SRC_IMM]    = 1'b1;
				writeback_bus[WB_REG_WRITE] = 1'b1;
				case (opcode)
					OP_ADDI: aluop = ALUOP_ADD;
					OP_SLTI: aluop = ALUOP_SLT;
					OP_ANDI: aluop = ALUOP_AND;
					OP_ORI:  aluop = ALUOP_OR;
					OP_XORI: aluop = ALUOP_XOR;
					default: aluop = ALUOP_LUI;
				endcase
			end

			OP_BEQ, OP_BNE:
			begin
				aluop                     = ALUOP_SLT;  // Compare by subtraction
				memory_bus[MEM_BRANCH]    = 1'b1;
				memory_bus[MEM_BRANCH_NE] = (opcode == OP_BNE);
			end

			OP_J:
			begin
				ex_flags[EX_JUMP] = 1'b1;
				alu_used          = 1'b0;  // Low bits are target, not funct
			end
			OP_JAL:
			begin
				ex_flags[EX_JUMP]           = 1'b1;
				writeback_bus[WB_REG_WRITE] = 1'b1;
				alu_used                    = 1'b0;
			end

			default:
				alu_used = 1'b0;
		endcase
	end

endmodule

// File: control/alu_control.sv
`timescale 1ns/100ps

module alu_control (
	input  logic [5:0]             funct,
	input  control_pkg::aluop_t    aluop,
	output control_pkg::alu_code_t alu_code
);
	import isa_pkg::*;
	import control_pkg::*;

	always_comb
	begin
		case (aluop)
			ALUOP_RTYPE:
			begin
				case (funct)
					FUNCT_SLL:              alu_code = SLL;
					FUNCT_SRL:              alu_code = SRL;
					FUNCT_SRA:              alu_code = SRA;
					FUNCT_SLLV:             alu_code = SLLV;
					FUNCT_SRLV:             alu_code = SRLV;
					FUNCT_SRAV:             alu_code = SRAV;
					FUNCT_ADD, FUNCT_ADDU:  alu_code = ADD;  // No overflow trap
					FUNCT_SUB, FUNCT_SUBU:  alu_code = SUB;
					FUNCT_AND:              alu_code = AND;
					FUNCT_OR:               alu_code = OR;
					FUNCT_XOR:              alu_code = XOR;
					FUNCT_NOR:              alu_code = NOR;
					FUNCT_SLT:              alu_code = SLT;
					FUNCT_SLTU:             alu_code = SLTU;
					default:                alu_code = SLL;  // JR, JALR and the rest
				endcase
			end
			ALUOP_ADD: alu_code = ADD;  // Address and ADDI
			ALUOP_AND: alu_code = AND;
			ALUOP_OR:  alu_code = OR;
			ALUOP_XOR: alu_code = XOR;
			ALUOP_SLT: alu_code = SUB;
			ALUOP_LUI: alu_code = LUI;
			default:   alu_code = ADD;
		endcase
	end

endmodule

// File: fetch/instr_fetch.sv
`timescale 1ns/100ps
`include "decode_settings.svh"

module instr_fetch (
	input  logic                          clk,
	input  logic                          reset,

	// Wishbone classic, read only
	output logic                          wb_cyc,
	output logic                          wb_stb,
	output logic [`DECODE_ADDR_WIDTH-1:0] wb_adr,
	input  logic                          wb_ack,
	input  logic [31:0]                   wb_rdata,

	// To decode
	output isa_pkg::instr_word_t          instr,
	output logic [31:0]                   instr_pc,
	output logic                          instr_valid,
	input  logic                          instr_ready
);

	logic [31:0] pc;        // Address of the word being fetched
	logic        ack_edge;
	logic        has_room;  // Buffer empty or drained this cycle

	assign ack_edge = wb_cyc && wb_ack;
	assign has_room = !instr_valid || instr_ready;

	assign wb_stb = wb_cyc;  // Classic cycle, stb follows cyc
	assign wb_adr = pc[`DECODE_ADDR_WIDTH+1:2];

	////////////////////////////////////////////////////////////////////////////
	// Bus cycle and PC

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_cyc <= 1'b0;
			pc     <= `DECODE_RESET_PC;
		end
		else if (ack_edge)
		begin
			wb_cyc <= 1'b0;  // Idle for at least one cycle
			pc     <= pc + `DECODE_PC_STEP;
		end
		else if (!wb_cyc && has_room)
		begin
			wb_cyc <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// One-entry buffer

	always_ff @(posedge clk)
	begin
		if (reset)
			instr_valid <= 1'b0;
		else if (ack_edge)
			instr_valid <= 1'b1;  // Buffer is always empty here
		else if (instr_ready)
			instr_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (ack_edge)
		begin
			instr    <= wb_rdata;
			instr_pc <= pc;
		end
	end

endmodule

// File: common/control_pkg.sv
package control_pkg;

	typedef enum logic [2:0] {
		ALUOP_RTYPE = 3'd0,  // ALU code from funct
		ALUOP_ADD   = 3'd1,
		ALUOP_AND   = 3'd2,
		ALUOP_OR    = 3'd3,
		ALUOP_XOR   = 3'd4,
		ALUOP_SLT   = 3'd6,  // Branches and SLTI
		ALUOP_LUI   = 3'd7
	} aluop_t;

	typedef enum logic [3:0] {
		SLL  = 4'd0,
		SRL  = 4'd1,
		SRA  = 4'd2,
		SLLV = 4'd3,
		SRLV = 4'd4,
		SRAV = 4'd5,
		ADD  = 4'd6,
		SUB  = 4'd7,
		AND  = 4'd8,
		OR   = 4'd9,
		XOR  = 4'd10,
		NOR  = 4'd11,
		SLT  = 4'd12,
		SLTU = 4'd13,
		LUI  = 4'd14
	} alu_code_t;

	localparam int EXECUTE_BUS_W   = 9;
	localparam int MEMORY_BUS_W    = 9;
	localparam int WRITEBACK_BUS_W = 2;

	// Execute bus
	localparam int EX_REG_DST       = 8;
	localparam int EX_ALU_SRC_SHAMT = 7;
	localparam int EX_ALU_SRC_IMM   = 6;
	localparam int EX_JUMP          = 5;
	localparam int EX_JUMP_REG      = 4;
	localparam int EX_ALU_CODE_MSB  = 3;
	localparam int EX_ALU_CODE_LSB  = 0;

	// Memory bus
	localparam int MEM_BRANCH_NE  = 8;
	localparam int MEM_STORE_BYTE = 7;
	localparam int MEM_STORE_HALF = 6;
	localparam int MEM_LOAD_BYTE  = 5;
	localparam int MEM_LOAD_HALF  = 4;
	localparam int MEM_UNSIGNED   = 3;
	localparam int MEM_BRANCH     = 2;
	localparam int MEM_READ       = 1;
	localparam int MEM_WRITE      = 0;

	// Write-back bus
	localparam int WB_REG_WRITE  = 1;
	localparam int WB_MEM_TO_REG = 0;

endpackage

// File: common/isa_pkg.sv
package isa_pkg;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LB    = 6'b100000;
	localparam logic [5:0] OP_LH    = 6'b100001;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_LBU   = 6'b100100;
	localparam logic [5:0] OP_LHU   = 6'b100101;
	localparam logic [5:0] OP_LWU   = 6'b100111;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SH    = 6'b101001;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function field
	localparam logic [5:0] FUNCT_SLL  = 6'b000000;
	localparam logic [5:0] FUNCT_SRL  = 6'b000010;
	localparam logic [5:0] FUNCT_SRA  = 6'b000011;
	localparam logic [5:0] FUNCT_SLLV = 6'b000100;
	localparam logic [5:0] FUNCT_SRLV = 6'b000110;
	localparam logic [5:0] FUNCT_SRAV = 6'b000111;
	localparam logic [5:0] FUNCT_JR   = 6'b001000;
	localparam logic [5:0] FUNCT_JALR = 6'b001001;
	localparam logic [5:0] FUNCT_ADD  = 6'b100000;
	localparam logic [5:0] FUNCT_ADDU = 6'b100001;
	localparam logic [5:0] FUNCT_SUB  = 6'b100010;
	localparam logic [5:0] FUNCT_SUBU = 6'b100011;
	localparam logic [5:0] FUNCT_AND  = 6'b100100;
	localparam logic [5:0] FUNCT_OR   = 6'b100101;
	localparam logic [5:0] FUNCT_XOR  = 6'b100110;
	localparam logic [5:0] FUNCT_NOR  = 6'b100111;
	localparam logic [5:0] FUNCT_SLT  = 6'b101010;
	localparam logic [5:0] FUNCT_SLTU = 6'b101011;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_form_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_form_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} j_form_t;

	// Same 32-bit word, three decodings
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
		j_form_t j_form;
	} instr_word_t;

endpackage

// File: common/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Wishbone side

// Word address, byte address bits [1:0] are dropped
`define DECODE_ADDR_WIDTH 30

// First instruction fetched after reset
`define DECODE_RESET_PC 32'h0000_0000

////////////////////////////////////////////////////////////////////////////
// Decode front end

`define DECODE_PC_STEP 32'd4   // No branch resolution here
`define DECODE_LINK_REG 5'd31  // Link target of JAL and JALR

`endif
